/* axi_ram.f */
+incdir+verilog
verilog/axi_ram_pkg.sv
verilog/axi_ram_cmd_queue.sv
verilog/axi_ram_write.sv
verilog/axi_ram_read.sv
verilog/axi_ram_bank.sv
verilog/axi_ram.sv
verif/axi_ram_properties.sv
verif/axi_ram_tb.sv

/* Makefile */
# Verilator build and run of the AXI4 RAM testbench
VERILATOR ?= verilator
TOP       ?= axi_ram_tb
BUILD_DIR ?= build

VFLAGS = --binary --timing --assert --timescale 1ns/10ps \
	--top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR, TOP, BUILD_DIR"

test:
	$(VERILATOR) $(VFLAGS) -f axi_ram.f
	$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* verif/axi_ram_tb.sv */
// Testbench for the AXI4 RAM slave; runs a table of bursts and checks them against a model
`timescale 1ns/10ps
`include "axi_ram_settings.svh"

module axi_ram_tb;

	localparam int AW = `AXI_RAM_ADDR_WIDTH;
	localparam int WAW = `AXI_RAM_WORD_ADDR_WIDTH;
	localparam int DW = `AXI_RAM_DATA_WIDTH;
	localparam int SW = `AXI_RAM_STRB_WIDTH;
	localparam int IW = `AXI_RAM_ID_WIDTH;
	localparam int ADDR_LSB = AW - WAW;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLES_PER_BEAT = 40;
	localparam int NUM_TESTS = 16;
	localparam int OP_WRITE = 0;
	localparam int OP_READ = 1;
	// Two AW commands back to back, then both W bursts, then both responses
	localparam int OP_PAIR = 2;

	logic aclk = 1'b0;
	logic aresetn;
	logic [IW-1:0] awid, arid, bid, rid;
	logic [AW-1:0] awaddr, araddr;
	logic [7:0] awlen, arlen;
	logic [2:0] awsize, arsize;
	logic [1:0] awburst, arburst;
	logic awvalid, awready, arvalid, arready;
	logic [DW-1:0] wdata, rdata;
	logic [SW-1:0] wstrb;
	logic wlast, wvalid, wready;
	logic bvalid, bready, rlast, rvalid, rready;
	axi_ram_pkg::resp_t bresp, rresp;

	logic [DW-1:0] ref_mem [`AXI_RAM_DEPTH];
	logic [31:0] rng_state = 32'h260d_8863;
	int cycle_count = 0;
	int cycle_limit = 32'h7fff_ffff;

	// Stimulus table
	int n_tests = 0;
	string t_name [NUM_TESTS];
	int t_op [NUM_TESTS];
	logic [AW-1:0] t_addr [NUM_TESTS];
	int t_len [NUM_TESTS];
	logic [SW-1:0] t_strb [NUM_TESTS];
	logic [IW-1:0] t_id [NUM_TESTS];
	bit t_bp [NUM_TESTS];

	axi_ram dut (.*);

	always #2 aclk = ~aclk;

	always @(posedge aclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == cycle_limit)
			fail_run($sformatf("Timeout: run did not complete within %0d cycles", cycle_limit));
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Burst address wraps from the top word to word zero
	function automatic logic [WAW-1:0] next_word(input logic [WAW-1:0] word);
		return (word == WAW'(`AXI_RAM_DEPTH - 1)) ? '0 : word + WAW'(1);
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
			fail_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic add_entry(input string name, input int op, input logic [AW-1:0] addr,
			input int len, input logic [SW-1:0] strb, input logic [IW-1:0] id, input bit bp);
		t_name[n_tests] = name;
		t_op[n_tests] = op;
		t_addr[n_tests] = addr;
		t_len[n_tests] = len;
		t_strb[n_tests] = strb;
		t_id[n_tests] = id;
		t_bp[n_tests] = bp;
		n_tests++;
	endtask

	////////////////////////////////////////////////////////////
	// Master tasks, entered and left on a falling edge

	task automatic send_aw(input logic [AW-1:0] addr, input int len, input logic [IW-1:0] id);
		awid = id;
		awaddr = addr;
		awlen = 8'(len);
		awsize = 3'($clog2(SW));
		awburst = 2'b01;
		awvalid = 1'b1;
		#1;
		while (!awready) begin
			@(negedge aclk);
			#1;
		end
		@(negedge aclk);
		awvalid = 1'b0;
	endtask

	task automatic send_w(input logic [AW-1:0] addr, input int len, input logic [SW-1:0] strb);
		logic [WAW-1:0] word;
		word = addr[AW-1:ADDR_LSB];
		for (int beat = 0; beat <= len; beat++) begin
			wdata = next_random();
			wstrb = strb;
			wlast = (beat == len);
			wvalid = 1'b1;
			#1;
			while (!wready) begin
				@(negedge aclk);
				#1;
			end
			// Beat transfers at the coming rising edge
			for (int lane = 0; lane < SW; lane++) begin
				if (strb[lane])
					ref_mem[word][lane*8 +: 8] = wdata[lane*8 +: 8];
			end
			word = next_word(word);
			@(negedge aclk);
		end
		wvalid = 1'b0;
		wlast = 1'b0;
	endtask

	task automatic recv_b(input string name, input logic [IW-1:0] id, input bit bp);
		logic [31:0] rnd;
		bit done;
		done = 1'b0;
		while (!done) begin
			rnd = next_random();
			bready = bp ? (rnd[0] | rnd[1]) : 1'b1;
			#1;
			if (bvalid && bready) begin
				check_value($sformatf("%s bid", name), 32'(id), 32'(bid));
				check_value($sformatf("%s bresp", name), 32'(axi_ram_pkg::OKAY), 32'(bresp));
				done = 1'b1;
			end
			@(negedge aclk);
		end
		bready = 1'b0;
	endtask

	task automatic send_ar(input logic [AW-1:0] addr, input int len, input logic [IW-1:0] id);
		arid = id;
		araddr = addr;
		arlen = 8'(len);
		arsize = 3'($clog2(SW));
		arburst = 2'b01;
		arvalid = 1'b1;
		#1;
		while (!arready) begin
			@(negedge aclk);
			#1;
		end
		@(negedge aclk);
		arvalid = 1'b0;
	endtask

	task automatic recv_r(input string name, input logic [AW-1:0] addr, input int len,
			input logic [IW-1:0] id, input bit bp);
		logic [31:0] rnd;
		logic [WAW-1:0] word;
		int beat;
		word = addr[AW-1:ADDR_LSB];
		beat = 0;
		while (beat <= len) begin
			rnd = next_random();
			rready = bp ? (rnd[0] | rnd[1]) : 1'b1;
			#1;
			if (rvalid && rready) begin
				check_value($sformatf("%s beat %0d rdata", name, beat), ref_mem[word], rdata);
				check_value($sformatf("%s beat %0d rid", name, beat), 32'(id), 32'(rid));
				check_value($sformatf("%s beat %0d rresp", name, beat),
					32'(axi_ram_pkg::OKAY), 32'(rresp));
				check_value($sformatf("%s beat %0d rlast", name, beat),
					32'(beat == len), 32'(rlast));
				word = next_word(word);
				beat++;
			end
			@(negedge aclk);
		end
		rready = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	initial begin
		int beats;
		aresetn = 1'b0;
		{awid, awaddr, awlen, awsize, awburst, awvalid} = '0;
		{arid, araddr, arlen, arsize, arburst, arvalid} = '0;
		{wdata, wstrb, wlast, wvalid, bready, rready} = '0;

		add_entry("single", OP_WRITE, 12'h000, 0, 4'hf, 4'd1, 1'b0);
		add_entry("single", OP_READ, 12'h000, 0, 4'h0, 4'd2, 1'b0);
		add_entry("incr4", OP_WRITE, 12'h010, 3, 4'hf, 4'd3, 1'b0);
		add_entry("incr4", OP_READ, 12'h010, 3, 4'h0, 4'd4, 1'b0);
		add_entry("incr16", OP_WRITE, 12'h040, 15, 4'hf, 4'd5, 1'b1);
		add_entry("incr16", OP_READ, 12'h040, 15, 4'h0, 4'd6, 1'b1);
		add_entry("incr256", OP_WRITE, 12'h100, 255, 4'hf, 4'd7, 1'b0);
		add_entry("incr256", OP_READ, 12'h100, 255, 4'h0, 4'd8, 1'b1);
		add_entry("strobe", OP_WRITE, 12'h010, 3, 4'b0101, 4'd9, 1'b0);
		add_entry("strobe", OP_READ, 12'h010, 3, 4'h0, 4'd10, 1'b0);
		// Unaligned start address, byte offset ignored
		add_entry("offset", OP_WRITE, 12'h203, 1, 4'b1010, 4'd11, 1'b1);
		add_entry("offset", OP_READ, 12'h201, 1, 4'h0, 4'd12, 1'b1);
		add_entry("pair", OP_PAIR, 12'h600, 3, 4'hf, 4'd13, 1'b1);
		add_entry("pair", OP_READ, 12'h600, 7, 4'h0, 4'd15, 1'b1);
		add_entry("wrap", OP_WRITE, 12'hff8, 5, 4'hf, 4'd0, 1'b1);
		add_entry("wrap", OP_READ, 12'hff8, 5, 4'h0, 4'd1, 1'b1);

		beats = 0;
		for (int i = 0; i < n_tests; i++)
			beats += (t_op[i] == OP_PAIR) ? 2 * (t_len[i] + 1) : t_len[i] + 1;
		cycle_limit = RESET_CYCLES + CYCLES_PER_BEAT * beats;

		repeat (RESET_CYCLES) @(negedge aclk);
		aresetn = 1'b1;
		@(negedge aclk);
		#1;
		check_value("reset awready", 32'd1, 32'(awready));
		check_value("reset arready", 32'd1, 32'(arready));
		check_value("reset bvalid", 32'd0, 32'(bvalid));
		check_value("reset rvalid", 32'd0, 32'(rvalid));
		check_value("reset wready", 32'd0, 32'(wready));
		@(negedge aclk);

		for (int i = 0; i < n_tests; i++) begin
			case (t_op[i])
				OP_WRITE: begin
					send_aw(t_addr[i], t_len[i], t_id[i]);
					send_w(t_addr[i], t_len[i], t_strb[i]);
					recv_b(t_name[i], t_id[i], t_bp[i]);
				end
				OP_PAIR: begin
					send_aw(t_addr[i], t_len[i], t_id[i]);
					send_aw(t_addr[i] + AW'((t_len[i] + 1) * SW), t_len[i], t_id[i] + 4'd1);
					send_w(t_addr[i], t_len[i], t_strb[i]);
					send_w(t_addr[i] + AW'((t_len[i] + 1) * SW), t_len[i], t_strb[i]);
					recv_b(t_name[i], t_id[i], t_bp[i]);
					recv_b(t_name[i], t_id[i] + 4'd1, t_bp[i]);
				end
				default: begin
					send_ar(t_addr[i], t_len[i], t_id[i]);
					recv_r(t_name[i], t_addr[i], t_len[i], t_id[i], t_bp[i]);
				end
			endcase
		end

		$display("Test passed");
		$finish;
	end

endmodule

/* verif/axi_ram_properties.sv */
// Protocol assertions on the AXI4 RAM slave ports, bound onto every axi_ram instance
`timescale 1ns/10ps
`include "axi_ram_settings.svh"

module axi_ram_properties (
	input logic                           aclk,
	input logic                           aresetn,
	input logic [7:0]                     arlen,
	input logic                           arvalid,
	input logic                           arready,
	input logic [`AXI_RAM_ID_WIDTH-1:0]   rid,
	input logic [`AXI_RAM_DATA_WIDTH-1:0] rdata,
	input logic                           rlast,
	input logic                           rvalid,
	input logic                           rready,
	input logic [`AXI_RAM_ID_WIDTH-1:0]   bid,
	input logic                           bvalid,
	input logic                           bready
);

	// Lengths of accepted read bursts, oldest at len_rptr
	logic [8:0] burst_len [0:3];
	logic [1:0] len_wptr;
	logic [1:0] len_rptr;
	logic [8:0] beat_cnt;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			len_wptr <= 2'd0;
			len_rptr <= 2'd0;
			beat_cnt <= 9'd0;
		end else begin
			if (arvalid && arready)
				len_wptr <= len_wptr + 2'd1;
			if (rvalid && rready) begin
				if (rlast) begin
					beat_cnt <= 9'd0;
					len_rptr <= len_rptr + 2'd1;
				end else begin
					beat_cnt <= beat_cnt + 9'd1;
				end
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (arvalid && arready)
			burst_len[len_wptr] <= {1'b0, arlen} + 9'd1;
	end

	////////////////////////////////////////////////////////////
	r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid) && $stable(rlast))
		else $error("R channel changed before RREADY");

	b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		bvalid && !bready |=> bvalid && $stable(bid))
		else $error("BVALID dropped before BREADY");

	rlast_needs_rvalid: assert property (@(posedge aclk) disable iff (!aresetn)
		rlast |-> rvalid)
		else $error("RLAST high without RVALID");

	burst_beats: assert property (@(posedge aclk) disable iff (!aresetn)
		rvalid && rready && rlast |-> beat_cnt + 9'd1 == burst_len[len_rptr])
		else $error("R beat count differs from ARLEN plus one");

endmodule

bind axi_ram axi_ram_properties props (.*);

/* verilog/axi_ram.sv */
// AXI4 RAM slave top level; instantiate this and connect an AXI4 master to its ports
`timescale 1ns/10ps
`include "axi_ram_settings.svh"

module axi_ram (
	input  logic                           aclk,
	input  logic                           aresetn,
	// Write address
	input  logic [`AXI_RAM_ID_WIDTH-1:0]   awid,
	input  logic [`AXI_RAM_ADDR_WIDTH-1:0] awaddr,
	input  logic [7:0]                     awlen,
	input  logic [2:0]                     awsize,
	input  logic [1:0]                     awburst,
	input  logic                           awvalid,
	output logic                           awready,
	// Write data
	input  logic [`AXI_RAM_DATA_WIDTH-1:0] wdata,
	input  logic [`AXI_RAM_STRB_WIDTH-1:0] wstrb,
	input  logic                           wlast,
	input  logic                           wvalid,
	output logic                           wready,
	// Write response
	output logic [`AXI_RAM_ID_WIDTH-1:0]   bid,
	output axi_ram_pkg::resp_t             bresp,
	output logic                           bvalid,
	input  logic                           bready,
	// Read address
	input  logic [`AXI_RAM_ID_WIDTH-1:0]   arid,
	input  logic [`AXI_RAM_ADDR_WIDTH-1:0] araddr,
	input  logic [7:0]                     arlen,
	input  logic [2:0]                     arsize,
	input  logic [1:0]                     arburst,
	input  logic                           arvalid,
	output logic                           arready,
	// Read data
	output logic [`AXI_RAM_ID_WIDTH-1:0]   rid,
	output logic [`AXI_RAM_DATA_WIDTH-1:0] rdata,
	output axi_ram_pkg::resp_t             rresp,
	output logic                           rlast,
	output logic                           rvalid,
	input  logic                           rready
);

	// Low address bits select a byte within the word
	localparam int ADDR_LSB = `AXI_RAM_ADDR_WIDTH - `AXI_RAM_WORD_ADDR_WIDTH;

	axi_ram_pkg::cmd_t                   aw_cmd, aw_q_cmd;
	axi_ram_pkg::cmd_t                   ar_cmd, ar_q_cmd;
	logic                                aw_q_valid, aw_q_ready;
	logic                                ar_q_valid, ar_q_ready;
	logic                                b_push_valid, b_push_ready;
	axi_ram_pkg::id_t                    b_push_id;
	logic                                mem_we, mem_re;
	logic [`AXI_RAM_STRB_WIDTH-1:0]      mem_be;
	logic [`AXI_RAM_WORD_ADDR_WIDTH-1:0] mem_waddr, mem_raddr;
	logic [`AXI_RAM_DATA_WIDTH-1:0]      mem_wdata, mem_rdata;

	// Size, burst type and WLAST are not needed, INCR full width only
	assign aw_cmd.id    = awid;
	assign aw_cmd.index = awaddr[`AXI_RAM_ADDR_WIDTH-1:ADDR_LSB];
	assign aw_cmd.len   = awlen;
	assign ar_cmd.id    = arid;
	assign ar_cmd.index = araddr[`AXI_RAM_ADDR_WIDTH-1:ADDR_LSB];
	assign ar_cmd.len   = arlen;

	assign bresp = axi_ram_pkg::OKAY;
	assign rresp = axi_ram_pkg::OKAY;

	////////////////////////////////////////////////////////////
	// Write path
	axi_ram_cmd_queue #(.payload_t(axi_ram_pkg::cmd_t)) aw_queue (
		.aclk, .aresetn,
		.in_valid(awvalid), .in_ready(awready), .in_data(aw_cmd),
		.out_valid(aw_q_valid), .out_ready(aw_q_ready), .out_data(aw_q_cmd)
	);

	axi_ram_write write_engine (
		.aclk, .aresetn,
		.cmd_valid(aw_q_valid), .cmd_ready(aw_q_ready), .cmd(aw_q_cmd),
		.wdata, .wstrb, .wvalid, .wready,
		.mem_we, .mem_be, .mem_waddr, .mem_wdata,
		.resp_valid(b_push_valid), .resp_ready(b_push_ready), .resp_id(b_push_id)
	);

	axi_ram_cmd_queue #(.payload_t(axi_ram_pkg::id_t)) b_queue (
		.aclk, .aresetn,
		.in_valid(b_push_valid), .in_ready(b_push_ready), .in_data(b_push_id),
		.out_valid(bvalid), .out_ready(bready), .out_data(bid)
	);

	////////////////////////////////////////////////////////////
	// Read path
	axi_ram_cmd_queue #(.payload_t(axi_ram_pkg::cmd_t)) ar_queue (
		.aclk, .aresetn,
		.in_valid(arvalid), .in_ready(arready), .in_data(ar_cmd),
		.out_valid(ar_q_valid), .out_ready(ar_q_ready), .out_data(ar_q_cmd)
	);

	axi_ram_read read_engine (
		.aclk, .aresetn,
		.cmd_valid(ar_q_valid), .cmd_ready(ar_q_ready), .cmd(ar_q_cmd),
		.mem_re, .mem_raddr, .mem_rdata,
		.rid, .rdata, .rlast, .rvalid, .rready
	);

	axi_ram_bank bank (
		.aclk,
		.mem_we, .mem_be, .mem_waddr, .mem_wdata,
		.mem_re, .mem_raddr, .mem_rdata
	);

endmodule

/* verilog/axi_ram_bank.sv */
// Word RAM with a byte-enabled write port and a registered read port
`timescale 1ns/10ps
`include "axi_ram_settings.svh"

module axi_ram_bank (
	input  logic                                aclk,
	input  logic                                mem_we,
	input  logic [`AXI_RAM_STRB_WIDTH-1:0]      mem_be,
	input  logic [`AXI_RAM_WORD_ADDR_WIDTH-1:0] mem_waddr,
	input  logic [`AXI_RAM_DATA_WIDTH-1:0]      mem_wdata,
	input  logic                                mem_re,
	input  logic [`AXI_RAM_WORD_ADDR_WIDTH-1:0] mem_raddr,
	output logic [`AXI_RAM_DATA_WIDTH-1:0]      mem_rdata
);

	logic [`AXI_RAM_DATA_WIDTH-1:0] mem [0:`AXI_RAM_DEPTH-1];

	// One lane per byte enable
	always_ff @(posedge aclk) begin
		for (int lane = 0; lane < `AXI_RAM_STRB_WIDTH; lane++) begin
			if (mem_we && mem_be[lane])
				mem[mem_waddr][lane*8 +: 8] <= mem_wdata[lane*8 +: 8];
		end
	end

	// Same-cycle collision returns the old word
	always_ff @(posedge aclk) begin
		if (mem_re)
			mem_rdata <= mem[mem_raddr];
	end

endmodule

/* verilog/axi_ram_read.sv */
// Read burst engine; issues bank reads under a credit of two and drives the R channel
`timescale 1ns/10ps
`include "axi_ram_settings.svh"

module axi_ram_read (
	input  logic                                aclk,
	input  logic                                aresetn,
	input  logic                                cmd_valid,
	output logic                                cmd_ready,
	input  axi_ram_pkg::cmd_t                   cmd,
	output logic                                mem_re,
	output logic [`AXI_RAM_WORD_ADDR_WIDTH-1:0] mem_raddr,
	input  logic [`AXI_RAM_DATA_WIDTH-1:0]      mem_rdata,
	output axi_ram_pkg::id_t                    rid,
	output logic [`AXI_RAM_DATA_WIDTH-1:0]      rdata,
	output logic                                rlast,
	output logic                                rvalid,
	input  logic                                rready
);

	localparam int WAW = `AXI_RAM_WORD_ADDR_WIDTH;
	localparam logic [WAW-1:0] TOP_INDEX = WAW'(`AXI_RAM_DEPTH - 1);

	logic                           active;
	axi_ram_pkg::id_t               id_q;
	logic [WAW-1:0]                 index_q;
	logic [7:0]                     remain_q;
	logic                           issue;
	logic                           issue_last;
	logic                           take;
	logic                           pop;

	// Tag of the read in flight through the bank
	logic                           rd_pend;
	axi_ram_pkg::id_t               rd_id;
	logic                           rd_last;

	logic [`AXI_RAM_DATA_WIDTH-1:0] buf_data [0:1];
	axi_ram_pkg::id_t               buf_id [0:1];
	logic                           buf_last [0:1];
	logic                           buf_wptr;
	logic                           buf_rptr;
	logic [1:0]                     buf_cnt;
	logic [1:0]                     held;

	////////////////////////////////////////////////////////////
	// Issue side

	// Beats in the buffer plus the one on its way
	assign held       = buf_cnt + {1'b0, rd_pend};
	assign pop        = rvalid && rready;
	assign issue      = active && ((held != 2'd2) || pop);
	assign issue_last = issue && (remain_q == 8'd0);
	// Next burst loads as the current one issues its last read
	assign cmd_ready  = !active || issue_last;
	assign take       = cmd_valid && cmd_ready;
	assign mem_re     = issue;
	assign mem_raddr  = index_q;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			active   <= 1'b0;
			rd_pend  <= 1'b0;
			buf_wptr <= 1'b0;
			buf_rptr <= 1'b0;
			buf_cnt  <= 2'd0;
		end else begin
			rd_pend <= issue;
			if (take)
				active <= 1'b1;
			else if (issue_last)
				active <= 1'b0;
			if (rd_pend)
				buf_wptr <= ~buf_wptr;
			if (pop)
				buf_rptr <= ~buf_rptr;
			buf_cnt <= buf_cnt + {1'b0, rd_pend} - {1'b0, pop};
		end
	end

	always_ff @(posedge aclk) begin
		if (take) begin
			id_q     <= cmd.id;
			index_q  <= cmd.index;
			remain_q <= cmd.len;
		end else if (issue) begin
			index_q  <= (index_q == TOP_INDEX) ? '0 : index_q + WAW'(1);
			remain_q <= remain_q - 8'd1;
		end
		if (issue) begin
			rd_id   <= id_q;
			rd_last <= (remain_q == 8'd0);
		end
		if (rd_pend) begin
			buf_data[buf_wptr] <= mem_rdata;
			buf_id[buf_wptr]   <= rd_id;
			buf_last[buf_wptr] <= rd_last;
		end
	end

	////////////////////////////////////////////////////////////
	// R channel, head of the output buffer
	assign rvalid = (buf_cnt != 2'd0);
	assign rdata  = buf_data[buf_rptr];
	assign rid    = buf_id[buf_rptr];
	assign rlast  = rvalid && buf_last[buf_rptr];

endmodule

/* verilog/axi_ram_write.sv */
// Write burst engine; takes AW commands, writes W beats to the bank, posts B IDs
`timescale 1ns/10ps
`include "axi_ram_settings.svh"

module axi_ram_write (
	input  logic                                aclk,
	input  logic                                aresetn,
	input  logic                                cmd_valid,
	output logic                                cmd_ready,
	input  axi_ram_pkg::cmd_t                   cmd,
	input  logic [`AXI_RAM_DATA_WIDTH-1:0]      wdata,
	input  logic [`AXI_RAM_STRB_WIDTH-1:0]      wstrb,
	input  logic                                wvalid,
	output logic                                wready,
	output logic                                mem_we,
	output logic [`AXI_RAM_STRB_WIDTH-1:0]      mem_be,
	output logic [`AXI_RAM_WORD_ADDR_WIDTH-1:0] mem_waddr,
	output logic [`AXI_RAM_DATA_WIDTH-1:0]      mem_wdata,
	output logic                                resp_valid,
	input  logic                                resp_ready,
	output axi_ram_pkg::id_t                    resp_id
);

	localparam int WAW = `AXI_RAM_WORD_ADDR_WIDTH;
	localparam logic [WAW-1:0] TOP_INDEX = WAW'(`AXI_RAM_DEPTH - 1);

	logic             busy;
	axi_ram_pkg::id_t id_q;
	logic [WAW-1:0]   index_q;
	logic [7:0]       remain_q;
	logic             beat;
	logic             last_beat;

	// Final beat waits for room in the B queue
	assign wready    = busy && ((remain_q != 8'd0) || resp_ready);
	assign beat      = wvalid && wready;
	assign last_beat = beat && (remain_q == 8'd0);
	assign cmd_ready = !busy;

	assign mem_we    = beat;
	assign mem_be    = wstrb;
	assign mem_waddr = index_q;
	assign mem_wdata = wdata;
	assign resp_id   = id_q;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			busy       <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			// One-cycle push, room was checked on the last beat
			resp_valid <= last_beat;
			if (cmd_valid && cmd_ready)
				busy <= 1'b1;
			else if (last_beat)
				busy <= 1'b0;
		end
	end

	// Burst position, wraps at the top of memory
	always_ff @(posedge aclk) begin
		if (cmd_valid && cmd_ready) begin
			id_q     <= cmd.id;
			index_q  <= cmd.index;
			remain_q <= cmd.len;
		end else if (beat) begin
			index_q  <= (index_q == TOP_INDEX) ? '0 : index_q + WAW'(1);
			remain_q <= remain_q - 8'd1;
		end
	end

endmodule

/* verilog/axi_ram_cmd_queue.sv */
// Two-entry valid/ready queue, instantiated with the payload type it carries
`timescale 1ns/10ps

module axi_ram_cmd_queue #(
	parameter type payload_t = logic
) (
	input  logic     aclk,
	input  logic     aresetn,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	payload_t   slot [0:1];
	logic       wptr;
	logic       rptr;
	logic [1:0] count;
	logic       push;
	logic       pop;

	// Ready from occupancy only, no path from out_ready
	assign in_ready  = (count != 2'd2);
	assign out_valid = (count != 2'd0);
	assign out_data  = slot[rptr];

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			wptr  <= 1'b0;
			rptr  <= 1'b0;
			count <= 2'd0;
		end else begin
			if (push)
				wptr <= ~wptr;
			if (pop)
				rptr <= ~rptr;
			count <= count + {1'b0, push} - {1'b0, pop};
		end
	end

	always_ff @(posedge aclk) begin
		if (push)
			slot[wptr] <= in_data;
	end

endmodule

/* verilog/axi_ram_pkg.sv */
// Types shared by the AXI4 RAM blocks; reference them as axi_ram_pkg::name
`include "axi_ram_settings.svh"

package axi_ram_pkg;

	// Transaction ID, also the payload of the write response queue
	typedef logic [`AXI_RAM_ID_WIDTH-1:0] id_t;

	// AXI response codes, only OKAY is ever returned
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_t;

	// Queued burst command
	typedef struct packed {
		id_t                                 id;
		logic [`AXI_RAM_WORD_ADDR_WIDTH-1:0] index;
		// Beats minus one, as in AxLEN
		logic [7:0]                          len;
	} cmd_t;

endpackage

/* verilog/axi_ram_settings.svh */
// Sizes of the AXI4 RAM; include this wherever bus or memory widths are needed
`ifndef AXI_RAM_SETTINGS_SVH
`define AXI_RAM_SETTINGS_SVH

// AXI ID width on AW, B, AR and R
`define AXI_RAM_ID_WIDTH 4

// Bus and memory word width
`define AXI_RAM_DATA_WIDTH 32
`define AXI_RAM_STRB_WIDTH (`AXI_RAM_DATA_WIDTH / 8)

// Memory size in words
`define AXI_RAM_DEPTH 1024

// Word index and byte address widths follow from the above
`define AXI_RAM_WORD_ADDR_WIDTH ($clog2(`AXI_RAM_DEPTH))
`define AXI_RAM_ADDR_WIDTH (`AXI_RAM_WORD_ADDR_WIDTH + $clog2(`AXI_RAM_STRB_WIDTH))

`endif
